//--- Bender.yml
package:
  name: spi_resp

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lane_pkg.sv
      - hw/frame_pkg.sv
      - hw/resp_dispatch.sv
      - hw/packet_disassembler.sv
      - hw/grant_arbiter.sv
      - hw/spi_resp_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tests/spi_resp_properties.sv
      - tests/tb_spi_resp.sv

//--- hw/frame_pkg.sv
`include "resp_config.svh"

package frame_pkg;

  // a full response word as it arrives from the core side
  typedef logic [`RESP_BITS-1:0] resp_t;

  // lane number that travels with a response and tags each chunk
  typedef logic [`LANE_BITS-1:0] lane_id_t;

  // one slice of a response as the SPI side sees it
  typedef logic [`SPI_BITS-1:0] chunk_t;

  // tagged output frame with the lane id in the upper bits
  localparam int FRAME_BITS = `LANE_BITS + `SPI_BITS;

  // the host splits this back into lane id and chunk
  typedef logic [FRAME_BITS-1:0] frame_t;

endpackage

//--- hw/grant_arbiter.sv
`timescale 1ns/10ps
`include "resp_config.svh"

module grant_arbiter (
  input  logic             clk,
  input  logic             reset,
  input  logic             chunk_val [`NUM_LANES],
  output logic             chunk_rdy [`NUM_LANES],
  input  frame_pkg::chunk_t chunk_msg [`NUM_LANES],
  output logic             out_val,
  input  logic             out_rdy,
  output frame_pkg::frame_t out_msg
);

  // lane that owns the output in this cycle
  frame_pkg::lane_id_t grant;
  // grant from the previous cycle, kept so a response is never split
  frame_pkg::lane_id_t last_grant;
  // lowest lane with a chunk waiting
  frame_pkg::lane_id_t enc_lane;

  // priority encoder that favours lane 0
  // scanning downwards leaves the lowest valid lane as the result
  always_comb begin
    enc_lane = '0;
    for (int i = `NUM_LANES - 1; i >= 0; i--) begin
      if (chunk_val[i]) begin
        enc_lane = frame_pkg::lane_id_t'(i);
      end
    end
  end

  // the previous owner keeps the output while its valid is still up
  // a disassembler drops valid between responses, which releases it
  always_comb begin
    if (chunk_val[last_grant]) begin
      grant = last_grant;
    end else begin
      grant = enc_lane;
    end
  end

  // only the granted lane sees ready, and only when the host can take data
  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      if (grant == frame_pkg::lane_id_t'(i)) begin
        chunk_rdy[i] = out_rdy;
      end else begin
        chunk_rdy[i] = 1'b0;
      end
    end
  end

  // out_val carries the ready as well, so it never rises while out_rdy is low
  assign out_val = chunk_val[grant] && chunk_rdy[grant];

  // the lane id goes on top so the host can tell responses apart
  assign out_msg = {grant, chunk_msg[grant]};

  always_ff @(posedge clk) begin
    if (reset) begin
      last_grant <= '0;
    end else begin
      last_grant <= grant;
    end
  end

endmodule

//--- hw/lane_pkg.sv
`include "resp_config.svh"

package lane_pkg;

  // two states are enough since a lane only ever holds one response
  typedef enum logic {
    DIS_IDLE = 1'b0,
    DIS_SEND = 1'b1
  } dis_state_t;

  // keep at least one counter bit even for a single-chunk response
  localparam int CNT_BITS = (`CHUNKS > 1) ? $clog2(`CHUNKS) : 1;

  // index of the chunk currently on the lane output
  typedef logic [CNT_BITS-1:0] chunk_cnt_t;

endpackage

//--- hw/packet_disassembler.sv
`timescale 1ns/10ps
`include "resp_config.svh"

module packet_disassembler (
  input  logic             clk,
  input  logic             reset,
  input  logic             resp_val,
  output logic             resp_rdy,
  input  frame_pkg::resp_t  resp_msg,
  output logic             chunk_val,
  input  logic             chunk_rdy,
  output frame_pkg::chunk_t chunk_msg
);

  lane_pkg::dis_state_t state;
  lane_pkg::chunk_cnt_t cnt;
  frame_pkg::resp_t     resp_buf;
  logic                 chunk_go;
  logic                 last_chunk;

  // a new response is only taken once the previous one has fully left
  assign resp_rdy  = (state == lane_pkg::DIS_IDLE);
  assign chunk_val = (state == lane_pkg::DIS_SEND);
  assign chunk_go  = chunk_val && chunk_rdy;

  assign last_chunk = (cnt == lane_pkg::chunk_cnt_t'(`CHUNKS - 1));

  // count zero picks the most significant slice of the word
  assign chunk_msg = resp_buf[(`CHUNKS - 1 - cnt) * `SPI_BITS +: `SPI_BITS];

  // going back to idle after the last chunk drops chunk_val for a cycle
  // and that gap is what lets the arbiter hand the grant to another lane
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= lane_pkg::DIS_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        lane_pkg::DIS_IDLE: begin
          if (resp_val) begin
            state <= lane_pkg::DIS_SEND;
            cnt   <= '0;
          end
        end
        lane_pkg::DIS_SEND: begin
          if (chunk_go) begin
            if (last_chunk) begin
              state <= lane_pkg::DIS_IDLE;
            end else begin
              cnt <= cnt + 1'b1;
            end
          end
        end
        default: begin
          state <= lane_pkg::DIS_IDLE;
        end
      endcase
    end
  end

  // the word is held unchanged while its chunks are sent
  always_ff @(posedge clk) begin
    if (resp_val && resp_rdy) begin
      resp_buf <= resp_msg;
    end
  end

endmodule

//--- hw/resp_config.svh
`ifndef RESP_CONFIG_SVH
`define RESP_CONFIG_SVH

// number of disassembler lanes behind the arbiter, at least 2
`define NUM_LANES 3
// width of one response word from the core
`define RESP_BITS 32
// width of one SPI chunk, RESP_BITS has to be a multiple of this
`define SPI_BITS 8
// lane number width, ceiling log2 of the lane count
`define LANE_BITS ($clog2(`NUM_LANES))
// chunks needed to carry one response word
`define CHUNKS (`RESP_BITS / `SPI_BITS)

`endif

//--- hw/resp_dispatch.sv
`timescale 1ns/10ps
`include "resp_config.svh"

module resp_dispatch (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_val,
  output logic               in_rdy,
  input  frame_pkg::lane_id_t in_lane,
  input  frame_pkg::resp_t    in_msg,
  output logic               lane_val [`NUM_LANES],
  input  logic               lane_rdy [`NUM_LANES],
  output frame_pkg::resp_t    resp_msg,
  output logic               bad_lane
);

  logic               buf_val;
  frame_pkg::lane_id_t buf_lane;
  frame_pkg::resp_t    buf_msg;
  logic               lane_take;
  logic               buf_done;

  // one-hot decode of the buffered lane, all zero for a lane that does not exist
  always_comb begin
    lane_take = 1'b0;
    for (int i = 0; i < `NUM_LANES; i++) begin
      lane_val[i] = buf_val && (buf_lane == frame_pkg::lane_id_t'(i));
      lane_take   = lane_take | (lane_val[i] & lane_rdy[i]);
    end
  end

  // a response for a missing lane sits in the buffer for exactly one cycle
  assign bad_lane = buf_val && (buf_lane >= `NUM_LANES);
  assign buf_done = lane_take || bad_lane;

  // the buffer can refill in the same cycle it drains
  assign in_rdy   = !buf_val || buf_done;
  assign resp_msg = buf_msg;

  always_ff @(posedge clk) begin
    if (reset) begin
      buf_val <= 1'b0;
    end else if (in_val && in_rdy) begin
      buf_val <= 1'b1;
    end else if (buf_done) begin
      buf_val <= 1'b0;
    end
  end

  // lane and word only mean something while buf_val is set
  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      buf_lane <= in_lane;
      buf_msg  <= in_msg;
    end
  end

endmodule

//--- hw/spi_resp_top.sv
`timescale 1ns/10ps
`include "resp_config.svh"

module spi_resp_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_val,
  output logic               in_rdy,
  input  frame_pkg::lane_id_t in_lane,
  input  frame_pkg::resp_t    in_msg,
  output logic               out_val,
  input  logic               out_rdy,
  output frame_pkg::frame_t   out_msg,
  output logic               bad_lane
);

  // dispatcher to lanes
  logic             lane_val [`NUM_LANES];
  logic             lane_rdy [`NUM_LANES];
  frame_pkg::resp_t  resp_msg;

  // lanes to arbiter
  logic             chunk_val [`NUM_LANES];
  logic             chunk_rdy [`NUM_LANES];
  frame_pkg::chunk_t chunk_msg [`NUM_LANES];

  resp_dispatch u_dispatch (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_lane  (in_lane),
    .in_msg   (in_msg),
    .lane_val (lane_val),
    .lane_rdy (lane_rdy),
    .resp_msg (resp_msg),
    .bad_lane (bad_lane)
  );

  // every lane sees the shared response word, only its own valid bit selects it
  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    packet_disassembler u_dis (
      .clk       (clk),
      .reset     (reset),
      .resp_val  (lane_val[i]),
      .resp_rdy  (lane_rdy[i]),
      .resp_msg  (resp_msg),
      .chunk_val (chunk_val[i]),
      .chunk_rdy (chunk_rdy[i]),
      .chunk_msg (chunk_msg[i])
    );
  end

  grant_arbiter u_arbiter (
    .clk       (clk),
    .reset     (reset),
    .chunk_val (chunk_val),
    .chunk_rdy (chunk_rdy),
    .chunk_msg (chunk_msg),
    .out_val   (out_val),
    .out_rdy   (out_rdy),
    .out_msg   (out_msg)
  );

endmodule

//--- tb.f
+incdir+hw
hw/lane_pkg.sv
hw/frame_pkg.sv
hw/resp_dispatch.sv
hw/packet_disassembler.sv
hw/grant_arbiter.sv
hw/spi_resp_top.sv
tests/spi_resp_properties.sv
tests/tb_spi_resp.sv

//--- tests/spi_resp_properties.sv
`timescale 1ns/10ps
`include "resp_config.svh"

module grant_arbiter_properties (
  input logic                clk,
  input logic                reset,
  input logic                chunk_val [`NUM_LANES],
  input logic                chunk_rdy [`NUM_LANES],
  input logic                out_val,
  input logic                out_rdy,
  input frame_pkg::lane_id_t grant
);

  // packed copies of the per-lane handshakes so they can be indexed and counted
  logic [`NUM_LANES-1:0] val_vec;
  logic [`NUM_LANES-1:0] rdy_vec;
  // number of assertion failures so far
  int                    prop_fails = 0;

  always_comb begin
    for (int i = 0; i < `NUM_LANES; i++) begin
      val_vec[i] = chunk_val[i];
      rdy_vec[i] = chunk_rdy[i];
    end
  end

  // ready goes back to at most one lane
  a_rdy_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(rdy_vec))
    else begin
      $error("chunk_rdy is high for more than one lane");
      prop_fails++;
    end

  // the output valid already contains the host ready
  a_val_needs_rdy: assert property (@(posedge clk) disable iff (reset) out_val |-> out_rdy)
    else begin
      $error("out_val is high while out_rdy is low");
      prop_fails++;
    end

  // a stalled lane keeps its valid up and so keeps the grant
  // this is what stops two responses from interleaving under back-pressure
  a_grant_sticky: assert property (@(posedge clk) disable iff (reset)
    (val_vec[grant] && !out_rdy) |=> (grant == $past(grant)))
    else begin
      $error("grant moved away from a stalled lane whose chunk_val was high");
      prop_fails++;
    end

endmodule

bind grant_arbiter grant_arbiter_properties u_props (
  .clk       (clk),
  .reset     (reset),
  .chunk_val (chunk_val),
  .chunk_rdy (chunk_rdy),
  .out_val   (out_val),
  .out_rdy   (out_rdy),
  .grant     (grant)
);

//--- tests/tb_spi_resp.sv
`timescale 1ns/10ps
`include "resp_config.svh"

module tb_spi_resp;

  localparam time CLK_PERIOD = 40ns;
  // eighteen responses over all tests with the lost and the dropped ones included
  localparam int TOTAL_CHUNKS = 18 * `CHUNKS;
  localparam time WATCHDOG_TIME = TOTAL_CHUNKS * 40 * CLK_PERIOD;

  logic                clk;
  logic                reset;
  logic                in_val;
  logic                in_rdy;
  frame_pkg::lane_id_t in_lane;
  frame_pkg::resp_t    in_msg;
  logic                out_val;
  logic                out_rdy;
  frame_pkg::frame_t   out_msg;
  logic                bad_lane;

  // frames seen on the output and the responses still expected there
  frame_pkg::frame_t   frames[$];
  frame_pkg::lane_id_t exp_lane[$];
  frame_pkg::resp_t    exp_msg[$];
  int                  bad_count;
  int                  test_errors;
  int                  pass_count;
  int                  fail_count;
  integer              seed;

  spi_resp_top u_dut (
    .clk      (clk),
    .reset    (reset),
    .in_val   (in_val),
    .in_rdy   (in_rdy),
    .in_lane  (in_lane),
    .in_msg   (in_msg),
    .out_val  (out_val),
    .out_rdy  (out_rdy),
    .out_msg  (out_msg),
    .bad_lane (bad_lane)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // outputs are taken at the rising edge where the handshake happens
  always @(posedge clk) begin
    if (!reset && out_val) begin
      frames.push_back(out_msg);
    end
    if (!reset && bad_lane) begin
      bad_count++;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  task automatic apply_reset();
    @(negedge clk);
    reset  = 1'b1;
    in_val = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic start_test();
    @(negedge clk);
    test_errors = 0;
    bad_count   = 0;
    frames.delete();
    exp_lane.delete();
    exp_msg.delete();
  endtask

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      pass_count++;
      $display("test %s passed", name);
    end else begin
      fail_count++;
      $display("test %s failed with %0d errors", name, test_errors);
    end
  endtask

  // holds the response on the input until the dispatcher takes it
  task automatic send_resp(input frame_pkg::lane_id_t lane, input frame_pkg::resp_t msg);
    int waited;
    waited = 0;
    @(negedge clk);
    in_val  = 1'b1;
    in_lane = lane;
    in_msg  = msg;
    @(posedge clk);
    while (!in_rdy && waited < 40 * `CHUNKS) begin
      waited++;
      @(posedge clk);
    end
    assert (in_rdy) else begin
      $display("in_rdy never rose for the response to lane %0d", lane);
      test_errors++;
    end
  endtask

  task automatic release_input();
    @(negedge clk);
    in_val = 1'b0;
  endtask

  // the frame count is read at the falling edge after the monitor has run
  task automatic wait_frames(input int n);
    int cycles;
    cycles = 0;
    while (frames.size() < n && cycles < n * 40) begin
      @(negedge clk);
      cycles++;
    end
    assert (frames.size() >= n) else begin
      $display("timed out after %0d cycles waiting for %0d frames", cycles, n);
      test_errors++;
    end
    // a few more cycles so that stray frames would show up
    repeat (2 * `CHUNKS) @(posedge clk);
  endtask

  // each response is CHUNKS frames in a row with the most significant byte first
  // ordered picks the head of the list and unordered picks the oldest response of that lane
  task automatic check_output(input bit ordered);
    int                  groups;
    int                  hit;
    frame_pkg::lane_id_t lane;
    frame_pkg::frame_t   expect_frame;
    groups = frames.size() / `CHUNKS;
    assert (frames.size() == exp_lane.size() * `CHUNKS) else begin
      $display("ERROR out_msg frame count: got 0x%0h expected 0x%0h",
               frames.size(), exp_lane.size() * `CHUNKS);
      test_errors++;
    end
    for (int g = 0; g < groups; g++) begin
      lane = frames[g * `CHUNKS][frame_pkg::FRAME_BITS-1 -: `LANE_BITS];
      hit  = -1;
      for (int i = 0; i < exp_lane.size(); i++) begin
        if (hit < 0 && (ordered || exp_lane[i] == lane)) begin
          hit = i;
        end
      end
      assert (hit >= 0) else begin
        $display("frames tagged with lane %0d came out with no response pending", lane);
        test_errors++;
      end
      if (hit >= 0) begin
        for (int c = 0; c < `CHUNKS; c++) begin
          expect_frame = {exp_lane[hit],
                          frame_pkg::chunk_t'(exp_msg[hit] >> ((`CHUNKS - 1 - c) * `SPI_BITS))};
          assert (frames[g * `CHUNKS + c] == expect_frame) else begin
            $display("ERROR out_msg: got 0x%0h expected 0x%0h",
                     frames[g * `CHUNKS + c], expect_frame);
            test_errors++;
          end
        end
        exp_lane.delete(hit);
        exp_msg.delete(hit);
      end
    end
  endtask

  task automatic single_response();
    start_test();
    out_rdy = 1'b1;
    exp_lane.push_back(2'd1);
    exp_msg.push_back(32'ha5c31e7b);
    send_resp(2'd1, 32'ha5c31e7b);
    release_input();
    wait_frames(`CHUNKS);
    check_output(1'b1);
    end_test("single_response");
  endtask

  // lane 2 takes the grant first and then lane 0 beats lane 1 on priority
  task automatic sticky_priority();
    start_test();
    out_rdy = 1'b0;
    send_resp(2'd2, 32'h11223344);
    send_resp(2'd1, 32'h55667788);
    send_resp(2'd0, 32'h99aabbcc);
    release_input();
    repeat (4) @(negedge clk);
    assert (frames.size() == 0) else begin
      $display("frames came out while out_rdy was low");
      test_errors++;
    end
    exp_lane = '{2'd2, 2'd0, 2'd1};
    exp_msg  = '{32'h11223344, 32'h99aabbcc, 32'h55667788};
    @(negedge clk);
    out_rdy = 1'b1;
    wait_frames(3 * `CHUNKS);
    check_output(1'b1);
    end_test("sticky_priority");
  endtask

  task automatic back_pressure();
    frame_pkg::lane_id_t lanes[10];
    frame_pkg::resp_t    msgs[10];
    bit                  toggle_done;
    start_test();
    toggle_done = 1'b0;
    for (int i = 0; i < 10; i++) begin
      lanes[i] = frame_pkg::lane_id_t'($unsigned($random(seed)) % `NUM_LANES);
      msgs[i]  = $random(seed);
      exp_lane.push_back(lanes[i]);
      exp_msg.push_back(msgs[i]);
    end
    fork
      begin
        for (int i = 0; i < 10; i++) begin
          send_resp(lanes[i], msgs[i]);
        end
        release_input();
        wait_frames(10 * `CHUNKS);
        toggle_done = 1'b1;
      end
      begin
        while (!toggle_done) begin
          @(negedge clk);
          out_rdy = ($random(seed) & 1) != 0;
        end
      end
    join
    @(negedge clk);
    out_rdy = 1'b1;
    check_output(1'b0);
    end_test("back_pressure");
  endtask

  task automatic invalid_lane();
    start_test();
    out_rdy = 1'b1;
    send_resp(2'd3, 32'hdeadbeef);
    release_input();
    repeat (8) @(posedge clk);
    assert (bad_count == 1) else begin
      $display("ERROR bad_lane high cycles: got 0x%0h expected 0x1", bad_count);
      test_errors++;
    end
    assert (frames.size() == 0) else begin
      $display("a response to a missing lane produced frames");
      test_errors++;
    end
    exp_lane.push_back(2'd0);
    exp_msg.push_back(32'h0badf00d);
    send_resp(2'd0, 32'h0badf00d);
    release_input();
    wait_frames(`CHUNKS);
    check_output(1'b1);
    end_test("invalid_lane");
  endtask

  // a response cut off by reset must vanish without a trace on the output
  task automatic reset_mid_response();
    int cycles;
    start_test();
    cycles  = 0;
    out_rdy = 1'b1;
    send_resp(2'd0, 32'hcafe1234);
    release_input();
    while (frames.size() < 2 && cycles < 40 * `CHUNKS) begin
      @(negedge clk);
      cycles++;
    end
    assert (frames.size() >= 2) else begin
      $display("the response before reset never started to come out");
      test_errors++;
    end
    apply_reset();
    frames.delete();
    repeat (2 * `CHUNKS + 4) begin
      @(posedge clk);
      assert (out_val == 1'b0) else begin
        $display("ERROR out_val after reset: got 0x%0h expected 0x0", out_val);
        test_errors++;
      end
      assert (in_rdy == 1'b1) else begin
        $display("ERROR in_rdy after reset: got 0x%0h expected 0x1", in_rdy);
        test_errors++;
      end
    end
    assert (frames.size() == 0) else begin
      $display("frames of the response lost in reset came out");
      test_errors++;
    end
    exp_lane.push_back(2'd2);
    exp_msg.push_back(32'h600dcafe);
    send_resp(2'd2, 32'h600dcafe);
    release_input();
    wait_frames(`CHUNKS);
    check_output(1'b1);
    end_test("reset_mid_response");
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    in_val     = 1'b0;
    in_lane    = '0;
    in_msg     = '0;
    out_rdy    = 1'b0;
    seed       = 32'h4cf6e379;
    pass_count = 0;
    fail_count = 0;
    apply_reset();
    single_response();
    sticky_priority();
    back_pressure();
    invalid_lane();
    reset_mid_response();
    $display("tests passed %0d, tests failed %0d, assertion failures %0d",
             pass_count, fail_count, u_dut.u_arbiter.u_props.prop_fails);
    if (fail_count == 0 && u_dut.u_arbiter.u_props.prop_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
